//--- hdl/wb_stream_params.svh
////////////////////////////////////////////////////////////////////////////
// address map, stream counts and queue depth of the stream accelerator
////////////////////////////////////////////////////////////////////////////

`ifndef WB_STREAM_PARAMS_SVH
`define WB_STREAM_PARAMS_SVH

// start of the register window
`define WB_STREAM_BASE 32'h3000_0000

// input stream i: status at +8i, data at +8i+4
`define WB_ISTREAM_STRIDE 8

// output stream: status at +16, data at +20
`define WB_OSTREAM_OFFSET 16

// control register, opcode in bits 1:0
`define WB_CTRL_OFFSET 32

`define WB_NUM_ISTREAM 2
`define WB_QUEUE_DEPTH 4

`endif

//--- hdl/wb_stream_pkg.sv
////////////////////////////////////////////////////////////////////////////
// word type, decoded bus access kinds and ALU opcodes
////////////////////////////////////////////////////////////////////////////

package wb_stream_pkg;

  // one bus and stream word
  typedef logic [31:0] word_t;

  // decoded kind of the current bus access
  typedef enum logic [2:0] {
    ACC_NONE           = 3'd0,
    ACC_ISTREAM_STATUS = 3'd1,
    ACC_ISTREAM_WRITE  = 3'd2,
    ACC_OSTREAM_STATUS = 3'd3,
    ACC_OSTREAM_READ   = 3'd4,
    ACC_CTRL_WRITE     = 3'd5,
    ACC_CTRL_READ      = 3'd6
  } wb_access_e;

  // stream ALU operation, encoding matches control bits 1:0
  typedef enum logic [1:0] {
    // a + b
    ALU_ADD = 2'd0,
    // a - b
    ALU_SUB = 2'd1,
    // a & b
    ALU_AND = 2'd2,
    // a ^ b
    ALU_XOR = 2'd3
  } alu_op_e;

endpackage

//--- hdl/queue_if.sv
////////////////////////////////////////////////////////////////////////////
// enqueue and dequeue sides of one stream queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface queue_if;
  import wb_stream_pkg::*;

  // enqueue side
  logic  enq_val;
  logic  enq_rdy;
  word_t enq_msg;

  // dequeue side
  logic  deq_val;
  logic  deq_rdy;
  word_t deq_msg;

  modport queue (
    input  enq_val, enq_msg, deq_rdy,
    output enq_rdy, deq_val, deq_msg
  );

  modport producer (
    input  enq_rdy,
    output enq_val, enq_msg
  );

  modport consumer (
    input  deq_val, deq_msg,
    output deq_rdy
  );

endinterface

//--- hdl/stream_fifo.sv
////////////////////////////////////////////////////////////////////////////
// circular buffer queue, val/rdy on both sides, no bypass path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_fifo #(
  parameter int DEPTH = 4
) (
  input logic clk,
  input logic rst_n_i,
  queue_if.queue q
);
  import wb_stream_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             enq_fire;
  logic             deq_fire;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // a full queue still takes a word when the head leaves in the same cycle
  assign q.enq_rdy = (count_q < CNT_W'(DEPTH)) || q.deq_rdy;
  assign q.deq_val = (count_q != '0);
  assign q.deq_msg = mem[rd_ptr_q];

  assign enq_fire = q.enq_val && q.enq_rdy;
  assign deq_fire = q.deq_val && q.deq_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (deq_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({enq_fire, deq_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr_q] <= q.enq_msg;
    end
  end

endmodule

//--- hdl/wb_stream_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone slave for the stream window: decode, ack, control register,
// queue strobes and read data mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "wb_stream_params.svh"

module wb_stream_ctrl (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  wb_stream_pkg::word_t  wb_adr_i,
  input  wb_stream_pkg::word_t  wb_dat_i,
  output logic                  wb_ack_o,
  output wb_stream_pkg::word_t  wb_dat_o,
  output wb_stream_pkg::alu_op_e alu_op_o,
  queue_if.producer             istream_a,
  queue_if.producer             istream_b,
  queue_if.consumer             ostream
);
  import wb_stream_pkg::*;

  localparam int IDX_W = $clog2(`WB_NUM_ISTREAM);
  localparam word_t ISTREAM_SPAN = `WB_NUM_ISTREAM * `WB_ISTREAM_STRIDE;

  logic             bus_req;
  logic             ack_q;
  word_t            offset;
  word_t            stream_ofs;
  logic [IDX_W-1:0] istream_idx;
  wb_access_e       acc;
  alu_op_e          alu_op_q;
  logic             istream_not_full;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign bus_req = wb_cyc_i && wb_stb_i;

  // addresses below the base wrap to large offsets and fall outside
  assign offset      = wb_adr_i - `WB_STREAM_BASE;
  assign stream_ofs  = offset % `WB_ISTREAM_STRIDE;
  assign istream_idx = IDX_W'(offset / `WB_ISTREAM_STRIDE);

  always_comb begin
    acc = ACC_NONE;
    if (bus_req) begin
      if (offset < ISTREAM_SPAN) begin
        if (stream_ofs == 32'd0 && !wb_we_i) begin
          acc = ACC_ISTREAM_STATUS;
        end else if (stream_ofs == 32'd4 && wb_we_i) begin
          acc = ACC_ISTREAM_WRITE;
        end
      end else if (offset == `WB_OSTREAM_OFFSET && !wb_we_i) begin
        acc = ACC_OSTREAM_STATUS;
      end else if (offset == `WB_OSTREAM_OFFSET + 4 && !wb_we_i) begin
        acc = ACC_OSTREAM_READ;
      end else if (offset == `WB_CTRL_OFFSET) begin
        acc = wb_we_i ? ACC_CTRL_WRITE : ACC_CTRL_READ;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ack and control register
  ////////////////////////////////////////////////////////////////////////////

  // one-cycle ack, never back to back
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      alu_op_q <= ALU_ADD;
    end else begin
      ack_q <= bus_req && !ack_q;
      if (ack_q && acc == ACC_CTRL_WRITE) begin
        alu_op_q <= alu_op_e'(wb_dat_i[1:0]);
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign alu_op_o = alu_op_q;

  // queue strobes, only in the ack cycle
  // a write into a full queue is lost, the queue ignores enq_val then
  assign istream_a.enq_val = ack_q && (acc == ACC_ISTREAM_WRITE) &&
                             (istream_idx == IDX_W'(0));
  assign istream_a.enq_msg = wb_dat_i;
  assign istream_b.enq_val = ack_q && (acc == ACC_ISTREAM_WRITE) &&
                             (istream_idx == IDX_W'(1));
  assign istream_b.enq_msg = wb_dat_i;

  // empty queue ignores deq_rdy, so no pop happens
  assign ostream.deq_rdy = ack_q && (acc == ACC_OSTREAM_READ);

  ////////////////////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////////////////////

  assign istream_not_full = (istream_idx == IDX_W'(0)) ? istream_a.enq_rdy
                                                        : istream_b.enq_rdy;

  always_comb begin
    case (acc)
      ACC_ISTREAM_STATUS: wb_dat_o = {31'b0, istream_not_full};
      ACC_OSTREAM_STATUS: wb_dat_o = {31'b0, ostream.deq_val};
      ACC_OSTREAM_READ:   wb_dat_o = ostream.deq_val ? ostream.deq_msg : '0;
      ACC_CTRL_READ:      wb_dat_o = {30'b0, alu_op_q};
      default:            wb_dat_o = '0;
    endcase
  end

endmodule

//--- hdl/stream_alu.sv
////////////////////////////////////////////////////////////////////////////
// stream ALU, pairs A and B words and registers one result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_alu (
  input logic                   clk,
  input logic                   rst_n_i,
  input wb_stream_pkg::alu_op_e alu_op_i,
  queue_if.consumer             opnd_a,
  queue_if.consumer             opnd_b,
  queue_if.producer             result
);
  import wb_stream_pkg::*;

  logic  res_val_q;
  word_t res_msg_q;
  word_t alu_out;
  logic  drain;
  logic  take;

  // result leaves the stage this cycle
  assign drain = res_val_q && result.enq_rdy;

  // take a pair only when the stage is free or frees up now
  assign take = opnd_a.deq_val && opnd_b.deq_val && (!res_val_q || result.enq_rdy);

  assign opnd_a.deq_rdy = take;
  assign opnd_b.deq_rdy = take;

  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_out = opnd_a.deq_msg + opnd_b.deq_msg;
      ALU_SUB: alu_out = opnd_a.deq_msg - opnd_b.deq_msg;
      ALU_AND: alu_out = opnd_a.deq_msg & opnd_b.deq_msg;
      ALU_XOR: alu_out = opnd_a.deq_msg ^ opnd_b.deq_msg;
      default: alu_out = '0;
    endcase
  end

  // result stage valid flag
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      res_val_q <= 1'b0;
    end else if (take) begin
      res_val_q <= 1'b1;
    end else if (drain) begin
      res_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_msg_q <= alu_out;
    end
  end

  assign result.enq_val = res_val_q;
  assign result.enq_msg = res_msg_q;

endmodule

//--- hdl/wb_stream_top.sv
////////////////////////////////////////////////////////////////////////////
// stream accelerator top: two input queues, ALU, output queue and
// the Wishbone control block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "wb_stream_params.svh"

module wb_stream_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_stream_pkg::word_t wb_adr_i,
  input  wb_stream_pkg::word_t wb_dat_i,
  output logic                 wb_ack_o,
  output wb_stream_pkg::word_t wb_dat_o
);
  import wb_stream_pkg::*;

  alu_op_e alu_op;

  // operand A, operand B and result queues
  queue_if istream_a_q ();
  queue_if istream_b_q ();
  queue_if ostream_q ();

  ////////////////////////////////////////////////////////////////////////////
  // queues
  ////////////////////////////////////////////////////////////////////////////

  stream_fifo #(
    .DEPTH (`WB_QUEUE_DEPTH)
  ) istream_a_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .q       (istream_a_q)
  );

  stream_fifo #(
    .DEPTH (`WB_QUEUE_DEPTH)
  ) istream_b_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .q       (istream_b_q)
  );

  stream_fifo #(
    .DEPTH (`WB_QUEUE_DEPTH)
  ) ostream_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .q       (ostream_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compute and bus control
  ////////////////////////////////////////////////////////////////////////////

  stream_alu stream_alu_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .alu_op_i (alu_op),
    .opnd_a   (istream_a_q),
    .opnd_b   (istream_b_q),
    .result   (ostream_q)
  );

  wb_stream_ctrl wb_stream_ctrl_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .alu_op_o  (alu_op),
    .istream_a (istream_a_q),
    .istream_b (istream_b_q),
    .ostream   (ostream_q)
  );

endmodule

//--- tests/wb_stream_checker.sv
////////////////////////////////////////////////////////////////////////////
// bus monitor with a reference model of the stream accelerator:
// operand queues, result order, opcode, ack rules and read data checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "wb_stream_params.svh"

module wb_stream_checker (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_stream_pkg::word_t wb_adr_i,
  input  wb_stream_pkg::word_t wb_dat_i,
  input  logic                 wb_ack_i,
  input  wb_stream_pkg::word_t wb_rdat_i,
  input  logic                 stat_chk_i,
  input  logic                 stat_exp_i,
  output int                   err_count_o,
  output int                   pending_o
);
  import wb_stream_pkg::*;

  word_t   qa [$];
  word_t   qb [$];
  // results inside the DUT, output queue plus ALU result stage
  word_t   res [$];
  alu_op_e op_q;
  logic    prev_ack;
  logic    prev_req;
  int      ack_cnt;
  word_t   offset;
  logic    req;

  assign offset = wb_adr_i - `WB_STREAM_BASE;
  assign req    = wb_cyc_i && wb_stb_i;

  initial err_count_o = 0;

  function automatic word_t apply_op(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      default: return a ^ b;
    endcase
  endfunction

  task automatic flag_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    err_count_o++;
  endtask

  task automatic compare_read(word_t want, string what);
    if (wb_rdat_i !== want) begin
      flag_error($sformatf("%s read 0x%08h, expected 0x%08h", what, wb_rdat_i, want));
    end
  endtask

  // pairs move on while the output side has room
  task automatic pair_operands();
    while (qa.size() > 0 && qb.size() > 0 && res.size() < `WB_QUEUE_DEPTH + 1) begin
      res.push_back(apply_op(op_q, qa.pop_front(), qb.pop_front()));
    end
  endtask

  task automatic push_operand(logic to_b);
    if (!to_b && qa.size() < `WB_QUEUE_DEPTH) begin
      qa.push_back(wb_dat_i);
    end else if (to_b && qb.size() < `WB_QUEUE_DEPTH) begin
      qb.push_back(wb_dat_i);
    end
    pair_operands();
  endtask

  // an empty output reads zero and pops nothing
  task automatic pop_result();
    word_t want;
    if (res.size() == 0) begin
      compare_read('0, "empty output data");
    end else begin
      want = res.pop_front();
      compare_read(want, "output data");
      pair_operands();
    end
  endtask

  task automatic handle_access();
    if (offset < `WB_NUM_ISTREAM * `WB_ISTREAM_STRIDE) begin
      if (offset % `WB_ISTREAM_STRIDE == 0 && !wb_we_i) begin
        if (stat_chk_i) compare_read({31'b0, stat_exp_i}, "input status");
      end else if (offset % `WB_ISTREAM_STRIDE == 4 && wb_we_i) begin
        push_operand(offset / `WB_ISTREAM_STRIDE != 0);
      end else if (!wb_we_i) begin
        compare_read('0, "unmapped");
      end
    end else if (offset == `WB_OSTREAM_OFFSET && !wb_we_i) begin
      if (stat_chk_i) compare_read({31'b0, stat_exp_i}, "output status");
    end else if (offset == `WB_OSTREAM_OFFSET + 4 && !wb_we_i) begin
      pop_result();
    end else if (offset == `WB_CTRL_OFFSET) begin
      if (wb_we_i) op_q = alu_op_e'(wb_dat_i[1:0]);
      else compare_read({30'b0, op_q}, "control");
    end else if (!wb_we_i) begin
      compare_read('0, "unmapped");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampled on the rising edge, before the DUT registers update
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n_i) begin
      qa.delete();
      qb.delete();
      res.delete();
      op_q       = ALU_ADD;
      prev_ack   = 1'b0;
      prev_req   = 1'b0;
      ack_cnt    = 0;
    end else begin
      if (wb_ack_i && !req) flag_error("ack seen without a bus request");
      if (wb_ack_i && prev_ack) flag_error("ack high in two consecutive cycles");
      if (req) begin
        ack_cnt += wb_ack_i;
      end else if (prev_req) begin
        if (ack_cnt != 1) flag_error($sformatf("access got %0d acks", ack_cnt));
        ack_cnt = 0;
      end
      if (req && wb_ack_i) handle_access();
      prev_ack = wb_ack_i;
      prev_req = req;
    end
    pending_o = res.size();
  end

endmodule

//--- tests/tb_wb_stream.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the stream accelerator: clock, reset, Wishbone host tasks
// and the test sequence
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "wb_stream_params.svh"

module tb_wb_stream;
  import wb_stream_pkg::*;

  localparam int    D        = `WB_QUEUE_DEPTH;
  localparam word_t ISTAT_A  = `WB_STREAM_BASE;
  localparam word_t IDATA_A  = `WB_STREAM_BASE + 4;
  localparam word_t ISTAT_B  = `WB_STREAM_BASE + `WB_ISTREAM_STRIDE;
  localparam word_t IDATA_B  = `WB_STREAM_BASE + `WB_ISTREAM_STRIDE + 4;
  localparam word_t OSTAT    = `WB_STREAM_BASE + `WB_OSTREAM_OFFSET;
  localparam word_t ODATA    = `WB_STREAM_BASE + `WB_OSTREAM_OFFSET + 4;
  localparam word_t CTRL     = `WB_STREAM_BASE + `WB_CTRL_OFFSET;
  // reset and unmapped checks, four opcodes, back-pressure, output full
  localparam int PLANNED_ACCESSES = 14 + 4 * (5 * D + 5) + (5 * D + 7) + (10 * D + 14);
  localparam int CYCLE_LIMIT      = 40 * PLANNED_ACCESSES + 100;

  logic  clk;
  logic  rst_n;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  word_t wb_adr;
  word_t wb_dat;
  logic  wb_ack;
  word_t wb_rdat;
  logic  stat_chk;
  logic  stat_exp;
  int    err_count;
  int    pending;
  word_t rand_state;
  int    cycle_cnt;
  word_t rdata;
  word_t r;
  int    npairs;

  wb_stream_top wb_stream_top_inst (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_rdat)
  );

  wb_stream_checker wb_stream_checker_inst (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat),
    .wb_ack_i    (wb_ack),
    .wb_rdat_i   (wb_rdat),
    .stat_chk_i  (stat_chk),
    .stat_exp_i  (stat_exp),
    .err_count_o (err_count),
    .pending_o   (pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone host, request held through the ack cycle
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic write, input word_t addr, input word_t wdata,
                            output word_t data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = write;
    wb_adr = addr;
    wb_dat = wdata;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data = wb_rdat;
    @(negedge clk);
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    stat_chk = 1'b0;
  endtask

  task automatic bus_write(input word_t addr, input word_t data);
    word_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic bus_read(input word_t addr, output word_t data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic read_status_expect(input word_t addr, input logic value);
    word_t unused;
    stat_chk = 1'b1;
    stat_exp = value;
    bus_read(addr, unused);
  endtask

  task automatic set_opcode(input logic [1:0] op);
    word_t upper;
    upper = next_rand();
    bus_write(CTRL, {upper[31:2], op});
  endtask

  // poll and pop until the model holds no more results, then expect idle
  task automatic drain_output();
    word_t d;
    while (pending > 0) begin
      bus_read(OSTAT, d);
      if (d[0]) bus_read(ODATA, d);
    end
    read_status_expect(OSTAT, 1'b0);
    read_status_expect(ISTAT_A, 1'b1);
    read_status_expect(ISTAT_B, 1'b1);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles, %0d errors so far",
             CYCLE_LIMIT, err_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat     = '0;
    stat_chk   = 1'b0;
    stat_exp   = 1'b0;
    rand_state = 32'hed05;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // state right after reset
    read_status_expect(ISTAT_A, 1'b1);
    read_status_expect(ISTAT_B, 1'b1);
    read_status_expect(OSTAT, 1'b0);
    bus_read(CTRL, rdata);
    bus_read(ODATA, rdata);

    // unmapped addresses ack, read 0 and leave the state alone
    bus_write(`WB_STREAM_BASE + 24, next_rand());
    bus_write(`WB_STREAM_BASE + 32'h40, next_rand());
    bus_write(`WB_STREAM_BASE - 4, next_rand());
    bus_read(`WB_STREAM_BASE + 28, rdata);
    bus_read(IDATA_A, rdata);
    bus_read(`WB_STREAM_BASE + 32'h40, rdata);
    read_status_expect(OSTAT, 1'b0);
    read_status_expect(ISTAT_A, 1'b1);
    bus_read(CTRL, rdata);

    // every opcode with a few random pairs
    for (int k = 0; k < 4; k++) begin
      set_opcode(2'(k));
      bus_read(CTRL, rdata);
      npairs = 1 + int'(next_rand() % D);
      repeat (npairs) begin
        bus_write(IDATA_A, next_rand());
        bus_write(IDATA_B, next_rand());
      end
      drain_output();
    end

    // A alone overflows, the extra word is lost
    r = next_rand();
    set_opcode(r[1:0]);
    repeat (D + 1) bus_write(IDATA_A, next_rand());
    read_status_expect(ISTAT_A, 1'b0);
    read_status_expect(ISTAT_B, 1'b1);
    repeat (D) bus_write(IDATA_B, next_rand());
    drain_output();

    // more pairs than the whole path holds
    r = next_rand();
    set_opcode(r[1:0]);
    repeat (2 * D + 2) begin
      bus_write(IDATA_A, next_rand());
      bus_write(IDATA_B, next_rand());
    end
    read_status_expect(ISTAT_A, 1'b0);
    read_status_expect(ISTAT_B, 1'b0);
    read_status_expect(OSTAT, 1'b1);
    drain_output();

    $display("errors: %0d", err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/wb_stream_pkg.sv
hdl/queue_if.sv
hdl/stream_fifo.sv
hdl/wb_stream_ctrl.sv
hdl/stream_alu.sv
hdl/wb_stream_top.sv
tests/wb_stream_checker.sv
tests/tb_wb_stream.sv
